//--- rtl/display_consts.svh
// ******************************
// display constants: reduced video mode,
// canvas and window geometry, background colour
// ******************************
`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

// horizontal timing (pixels), positive sync
`define H_ACTIVE    48
`define H_FP        4
`define H_SYNC      4
`define H_BP        8
`define H_TOTAL     (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)  // 64

// vertical timing (lines), positive sync
`define V_ACTIVE    24
`define V_FP        2
`define V_SYNC      2
`define V_BP        4
`define V_TOTAL     (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)  // 32

// canvas: 4 bits per pixel, 4 pixels per word
`define CANV_WIDTH  16
`define CANV_HEIGHT 8
`define CANV_SCALE  2
`define CANV_WORDS  32

// window placement on screen
`define WIN_STARTX  8
`define WIN_STARTY  4
`define WIN_WIDTH   (`CANV_WIDTH * `CANV_SCALE)   // 32
`define WIN_HEIGHT  (`CANV_HEIGHT * `CANV_SCALE)  // 16

`define BG_COLR     15'h0886  // RGB555, outside the window

`endif

//--- rtl/display_pkg.sv
// ******************************
// display types: canvas word, colour, palette index
// ******************************
package display_pkg;

    typedef logic [3:0] pal_idx_t;  // palette index, 16 colours

    // one canvas word, seen either as the host stores it
    // or as four packed pixels
    typedef union packed {
        logic [15:0]     raw;  // host write view
        pal_idx_t [3:0]  pix;  // pixel 0 in low nibble
    } canvas_word_t;

    // RGB555, red at the top
    typedef struct packed {
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
    } colour_t;

endpackage

//--- rtl/sync_bus_if.sv
// ******************************
// sync bus: per-pixel sync and qualifier flags
// ******************************
`timescale 1ns/1ns

interface sync_bus_if;
    logic de;      // active video
    logic hsync;   // horizontal sync, positive
    logic vsync;   // vertical sync, positive
    logic in_win;  // pixel lies inside canvas window

    // stage that produces the flags
    modport src (
        output de,
        output hsync,
        output vsync,
        output in_win
    );

    // stage that consumes them
    modport dst (
        input de,
        input hsync,
        input vsync,
        input in_win
    );
endinterface

//--- rtl/display_ctrl.sv
// ******************************
// display controller: screen counters, syncs,
// window test and canvas address generation
// ******************************
`timescale 1ns/1ns
`include "display_consts.svh"

module display_ctrl (
    input  logic        clk_pix,
    input  logic        rst_sys,
    sync_bus_if.src     s0,         // flags for the registered position
    output logic [4:0]  canv_addr,  // canvas word address
    output logic [1:0]  canv_sel    // pixel within the word
);

    logic [5:0] sx;  // horizontal position, 0..63
    logic [4:0] sy;  // vertical position, 0..31

    logic [5:0] win_x;     // offset into the window, screen pixels
    logic [4:0] win_y;
    logic [3:0] cx;        // canvas column
    logic [2:0] cy;        // canvas line
    logic       in_win_c;

    // screen counters, line wraps then frame wraps
    always_ff @(posedge clk_pix) begin
        if (rst_sys) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == 6'(`H_TOTAL - 1)) begin
            sx <= '0;
            sy <= (sy == 5'(`V_TOTAL - 1)) ? '0 : sy + 5'd1;  // next line
        end else begin
            sx <= sx + 6'd1;
        end
    end

    // window test
    assign in_win_c = (sx >= 6'(`WIN_STARTX)) && (sx < 6'(`WIN_STARTX + `WIN_WIDTH))
                   && (sy >= 5'(`WIN_STARTY)) && (sy < 5'(`WIN_STARTY + `WIN_HEIGHT));

    // screen to canvas coordinates
    assign win_x = sx - 6'(`WIN_STARTX);  // only meaningful inside window
    assign win_y = sy - 5'(`WIN_STARTY);
    assign cx    = 4'(win_x / 6'(`CANV_SCALE));
    assign cy    = 3'(win_y / 5'(`CANV_SCALE));

    // registered outputs, one cycle behind the counters
    always_ff @(posedge clk_pix) begin
        if (rst_sys) begin
            s0.de     <= 1'b0;
            s0.hsync  <= 1'b0;
            s0.vsync  <= 1'b0;
            s0.in_win <= 1'b0;
            canv_addr <= '0;
            canv_sel  <= '0;
        end else begin
            s0.de     <= (sx < 6'(`H_ACTIVE)) && (sy < 5'(`V_ACTIVE));
            s0.hsync  <= (sx >= 6'(`H_ACTIVE + `H_FP))
                      && (sx < 6'(`H_ACTIVE + `H_FP + `H_SYNC));
            s0.vsync  <= (sy >= 5'(`V_ACTIVE + `V_FP))
                      && (sy < 5'(`V_ACTIVE + `V_FP + `V_SYNC));  // whole lines
            s0.in_win <= in_win_c;
            if (in_win_c) begin
                canv_addr <= {cy, cx[3:2]};  // 4 words per canvas line
                canv_sel  <= cx[1:0];
            end else begin
                canv_addr <= '0;  // park outside the window
                canv_sel  <= '0;
            end
        end
    end

endmodule

//--- rtl/canvas_ram.sv
// ******************************
// canvas memory: host word writes, pixel reads
// ******************************
`timescale 1ns/1ns
`include "display_consts.svh"

module canvas_ram import display_pkg::*; (
    input  logic          clk_pix,
    input  logic          rst_sys,
    input  logic          canv_we,      // host write strobe
    input  logic [4:0]    canv_addr_w,  // host word address
    input  canvas_word_t  canv_data,    // host word
    input  logic [4:0]    canv_addr,    // read word from controller
    input  logic [1:0]    canv_sel,     // read nibble
    sync_bus_if.dst       s0,
    sync_bus_if.src       s1,
    output pal_idx_t      pix_idx       // registered pixel index
);

    canvas_word_t mem [`CANV_WORDS];  // 32 words x 4 pixels
    canvas_word_t rd_word;

    // host port stores the raw view
    always_ff @(posedge clk_pix) begin
        if (canv_we) mem[canv_addr_w].raw <= canv_data.raw;
    end

    assign rd_word = mem[canv_addr];

    // read port picks one pixel out of the word
    always_ff @(posedge clk_pix) begin
        pix_idx <= rd_word.pix[canv_sel];
    end

    // flags follow the data by one cycle
    always_ff @(posedge clk_pix) begin
        if (rst_sys) begin
            s1.de     <= 1'b0;
            s1.hsync  <= 1'b0;
            s1.vsync  <= 1'b0;
            s1.in_win <= 1'b0;
        end else begin
            s1.de     <= s0.de;
            s1.hsync  <= s0.hsync;
            s1.vsync  <= s0.vsync;
            s1.in_win <= s0.in_win;
        end
    end

endmodule

//--- rtl/palette_lut.sv
// ******************************
// palette: 16 RGB555 entries, registered lookup
// ******************************
`timescale 1ns/1ns

module palette_lut import display_pkg::*; (
    input  logic      clk_pix,
    input  logic      rst_sys,
    input  logic      pal_we,    // host write strobe
    input  pal_idx_t  pal_addr,  // entry to write
    input  colour_t   pal_data,  // new colour
    input  pal_idx_t  pix_idx,   // index from canvas
    sync_bus_if.dst   s1,
    sync_bus_if.src   s2,
    output colour_t   pix_colr   // looked-up colour
);

    colour_t pal [16];

    always_ff @(posedge clk_pix) begin
        if (pal_we) pal[pal_addr] <= pal_data;  // visible from next cycle
        pix_colr <= pal[pix_idx];
    end

    always_ff @(posedge clk_pix) begin
        if (rst_sys) begin
            s2.de     <= 1'b0;
            s2.hsync  <= 1'b0;
            s2.vsync  <= 1'b0;
            s2.in_win <= 1'b0;
        end else begin
            s2.de     <= s1.de;
            s2.hsync  <= s1.hsync;
            s2.vsync  <= s1.vsync;
            s2.in_win <= s1.in_win;
        end
    end

endmodule

//--- rtl/colour_expand.sv
// ******************************
// colour output: background fill, blanking,
// 5 to 8 bit widening
// ******************************
`timescale 1ns/1ns
`include "display_consts.svh"

module colour_expand import display_pkg::*; (
    input  logic        clk_pix,
    input  logic        rst_sys,
    sync_bus_if.dst     s2,
    input  colour_t     pix_colr,  // palette colour for this pixel
    output logic        hsync,
    output logic        vsync,
    output logic        de,
    output logic [7:0]  r,
    output logic [7:0]  g,
    output logic [7:0]  b
);

    colour_t out_colr;

    // blanking wins over the window test
    always_comb begin
        if (!s2.de)          out_colr = '0;
        else if (!s2.in_win) out_colr = colour_t'(`BG_COLR);
        else                 out_colr = pix_colr;
    end

    always_ff @(posedge clk_pix) begin
        if (rst_sys) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            r     <= '0;
            g     <= '0;
            b     <= '0;
        end else begin
            hsync <= s2.hsync;
            vsync <= s2.vsync;
            de    <= s2.de;
            r     <= {out_colr.r, out_colr.r[4:2]};  // replicate top bits into low bits
            g     <= {out_colr.g, out_colr.g[4:2]};
            b     <= {out_colr.b, out_colr.b[4:2]};
        end
    end

endmodule

//--- rtl/display_top.sv
// ******************************
// display pixel path top: controller plus
// canvas, palette and colour stages
// ******************************
`timescale 1ns/1ns

module display_top import display_pkg::*; (
    input  logic          clk_pix,
    input  logic          rst_sys,
    input  logic          canv_we,      // canvas word write
    input  logic [4:0]    canv_addr_w,
    input  canvas_word_t  canv_data,
    input  logic          pal_we,       // palette entry write
    input  pal_idx_t      pal_addr,
    input  colour_t       pal_data,
    output logic          hsync,
    output logic          vsync,
    output logic          de,
    output logic [7:0]    r,
    output logic [7:0]    g,
    output logic [7:0]    b
);

    sync_bus_if s0 ();  // controller -> canvas
    sync_bus_if s1 ();  // canvas -> palette
    sync_bus_if s2 ();  // palette -> colour

    logic [4:0] canv_addr;
    logic [1:0] canv_sel;
    pal_idx_t   pix_idx;
    colour_t    pix_colr;

    display_ctrl display_ctrl_inst (
        .clk_pix   (clk_pix),
        .rst_sys   (rst_sys),
        .s0        (s0.src),
        .canv_addr (canv_addr),
        .canv_sel  (canv_sel)
    );

    canvas_ram canvas_ram_inst (
        .clk_pix     (clk_pix),
        .rst_sys     (rst_sys),
        .canv_we     (canv_we),
        .canv_addr_w (canv_addr_w),
        .canv_data   (canv_data),
        .canv_addr   (canv_addr),
        .canv_sel    (canv_sel),
        .s0          (s0.dst),
        .s1          (s1.src),
        .pix_idx     (pix_idx)
    );

    palette_lut palette_lut_inst (
        .clk_pix  (clk_pix),
        .rst_sys  (rst_sys),
        .pal_we   (pal_we),
        .pal_addr (pal_addr),
        .pal_data (pal_data),
        .pix_idx  (pix_idx),
        .s1       (s1.dst),
        .s2       (s2.src),
        .pix_colr (pix_colr)
    );

    colour_expand colour_expand_inst (
        .clk_pix  (clk_pix),
        .rst_sys  (rst_sys),
        .s2       (s2.dst),
        .pix_colr (pix_colr),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .r        (r),
        .g        (g),
        .b        (b)
    );

endmodule

//--- testbench/display_props.sv
// ******************************
// bound properties on the display outputs for
// sync widths, line period, blanking and reset state
// ******************************
`timescale 1ns/1ns

module display_props (
    input  logic        clk_pix,
    input  logic        rst_sys,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        de,
    input  logic [7:0]  r,
    input  logic [7:0]  g,
    input  logic [7:0]  b
);

    logic [7:0] hs_len;   // cycles hsync has been high
    logic [7:0] hs_gap;   // cycles since the last hsync rise or 0 before the first
    logic       hs_prev;
    logic [7:0] vs_len;   // cycles vsync has been high
    int         err_cnt = 0;  // failed properties so far

    always_ff @(posedge clk_pix) begin
        if (rst_sys) begin
            hs_len  <= '0;
            hs_gap  <= '0;
            hs_prev <= 1'b0;
            vs_len  <= '0;
        end else begin
            hs_prev <= hsync;
            hs_len  <= hsync ? hs_len + 8'd1 : 8'd0;
            if (hsync && !hs_prev) hs_gap <= 8'd1;  // restart on rise
            else if (hs_gap != 8'd0 && hs_gap != 8'hff) hs_gap <= hs_gap + 8'd1;
            if (!vsync) vs_len <= 8'd0;
            else if (vs_len != 8'hff) vs_len <= vs_len + 8'd1;  // saturate
        end
    end

    hsync_width: assert property (@(posedge clk_pix) disable iff (rst_sys)
        $fell(hsync) |-> hs_len == 8'd4)
        else begin
            $error("hsync pulse is not 4 cycles wide");
            err_cnt++;
        end

    hsync_period: assert property (@(posedge clk_pix) disable iff (rst_sys)
        $rose(hsync) |-> (hs_gap == 8'd0 || hs_gap == 8'd64))
        else begin
            $error("hsync does not repeat every 64 cycles");
            err_cnt++;
        end

    vsync_width: assert property (@(posedge clk_pix) disable iff (rst_sys)
        $fell(vsync) |-> vs_len == 8'd128)
        else begin
            $error("vsync pulse is not 128 cycles wide");
            err_cnt++;
        end

    blank_black: assert property (@(posedge clk_pix) disable iff (rst_sys)
        !de |-> (r == 8'd0 && g == 8'd0 && b == 8'd0))
        else begin
            $error("colour outputs not black while de is low");
            err_cnt++;
        end

    reset_idle: assert property (@(posedge clk_pix)
        (rst_sys && $past(rst_sys)) |-> (!hsync && !vsync && !de))
        else begin
            $error("sync outputs active during reset");
            err_cnt++;
        end

endmodule

//--- testbench/display_tb.sv
// ******************************
// testbench for the display pixel path
// with every pixel checked against a screen model
// ******************************
`timescale 1ns/1ns
`include "display_consts.svh"

module display_tb import display_pkg::*; ();

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;  // 2048

    logic          clk_pix = 1'b0;
    logic          rst_sys;
    logic          canv_we;
    logic [4:0]    canv_addr_w;
    canvas_word_t  canv_data;
    logic          pal_we;
    pal_idx_t      pal_addr;
    colour_t       pal_data;
    logic          hsync;
    logic          vsync;
    logic          de;
    logic [7:0]    r;
    logic [7:0]    g;
    logic [7:0]    b;

    logic [31:0] rng;               // xorshift state
    logic [14:0] pal_model [16];    // host view of the palette
    logic [15:0] canv_model [32];   // host view of the canvas
    logic        sync_armed;        // model may lock on the next de rise
    pal_idx_t    upd_idx;

    logic model_on  = 1'b0;  // screen model running
    int   mx        = 0;     // model screen position
    int   my        = 0;
    int   frame_cnt = 0;     // full frames checked

    display_top display_top_inst (.*);

    bind display_top display_props display_props_inst (
        .clk_pix (clk_pix),
        .rst_sys (rst_sys),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .r       (r),
        .g       (g),
        .b       (b)
    );

    initial begin
        forever begin
            #5 clk_pix = ~clk_pix;  // 10 ns period
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 5 bit channel shifted up by 3 with its top 3 bits as the low end
    function automatic logic [7:0] widen_channel(input logic [4:0] c);
        return (8'(c) << 3) | 8'(c >> 2);
    endfunction

    function automatic logic in_window(input int x, input int y);
        return x >= `WIN_STARTX && x < `WIN_STARTX + `CANV_WIDTH * `CANV_SCALE
            && y >= `WIN_STARTY && y < `WIN_STARTY + `CANV_HEIGHT * `CANV_SCALE;
    endfunction

    // palette index of the canvas pixel under screen position x, y
    function automatic pal_idx_t pixel_index(input int x, input int y);
        int          cx;
        int          cy;
        logic [15:0] word;
        cx   = (x - `WIN_STARTX) / `CANV_SCALE;
        cy   = (y - `WIN_STARTY) / `CANV_SCALE;
        word = canv_model[5'((cy * `CANV_WIDTH + cx) / 4)];  // 4 pixels per word
        return 4'(word >> (4 * (cx % 4)));                   // pixel 0 lowest
    endfunction

    function automatic logic [14:0] expected_colour(input int x, input int y);
        if (x >= `H_ACTIVE || y >= `V_ACTIVE) return 15'd0;  // blanking
        if (!in_window(x, y)) return `BG_COLR;
        return pal_model[pixel_index(x, y)];
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_outputs_idle(input string phase);
        assert (!hsync && !vsync && !de && r == 8'd0 && g == 8'd0 && b == 8'd0)
            else stop_with_failure($sformatf("Mismatch at %0t ns: outputs not 0 %s",
                                             $time, phase));
    endtask

    task automatic wait_for_vsync(input int limit);
        int n;
        n = 0;
        while (!vsync && n < limit) begin
            @(negedge clk_pix);
            n++;
        end
        if (!vsync) stop_with_failure("Timed out waiting for vsync to go high");
    endtask

    task automatic wait_for_model_start(input int limit);
        int n;
        n = 0;
        while (!model_on && n < limit) begin
            @(negedge clk_pix);
            n++;
        end
        if (!model_on) stop_with_failure("Timed out waiting for de to start a frame");
    endtask

    task automatic wait_for_frames(input int target, input int limit);
        int n;
        n = 0;
        while (frame_cnt < target && n < limit) begin
            @(negedge clk_pix);
            n++;
        end
        if (frame_cnt < target) stop_with_failure("Timed out waiting for a frame to end");
    endtask

    // screen model that locks on the first de rise after arming
    always @(negedge clk_pix) begin
        logic [14:0] exp_c;
        logic        exp_de;
        logic        exp_hs;
        logic        exp_vs;
        if (display_top_inst.display_props_inst.err_cnt != 0)
            stop_with_failure("A bound property on the DUT outputs failed");
        if (sync_armed && !model_on && de) begin
            model_on = 1'b1;
            mx = 0;
            my = 0;
        end
        if (model_on) begin
            exp_de = (mx < `H_ACTIVE) && (my < `V_ACTIVE);
            exp_hs = (mx >= `H_ACTIVE + `H_FP) && (mx < `H_ACTIVE + `H_FP + `H_SYNC);
            exp_vs = (my >= `V_ACTIVE + `V_FP) && (my < `V_ACTIVE + `V_FP + `V_SYNC);
            exp_c  = expected_colour(mx, my);
            assert (de == exp_de && hsync == exp_hs && vsync == exp_vs)
                else stop_with_failure($sformatf(
                    "Mismatch at %0t ns: (%0d,%0d) de/hs/vs %b%b%b, expected %b%b%b",
                    $time, mx, my, de, hsync, vsync, exp_de, exp_hs, exp_vs));
            assert (r == widen_channel(exp_c[14:10]) && g == widen_channel(exp_c[9:5])
                    && b == widen_channel(exp_c[4:0]))
                else stop_with_failure($sformatf(
                    "Mismatch at %0t ns: (%0d,%0d) rgb %0d %0d %0d, expected colour %h",
                    $time, mx, my, r, g, b, exp_c));
            if (mx == `H_TOTAL - 1) begin  // end of line
                mx = 0;
                if (my == `V_TOTAL - 1) begin
                    my = 0;
                    frame_cnt++;
                end else begin
                    my++;
                end
            end else begin
                mx++;
            end
        end
    end

    initial begin
        logic [14:0] new_c;
        rst_sys     = 1'b1;
        canv_we     = 1'b0;
        canv_addr_w = '0;
        canv_data   = '0;
        pal_we      = 1'b0;
        pal_addr    = '0;
        pal_data    = '0;
        rng         = 32'd43011;
        sync_armed  = 1'b0;
        upd_idx     = '0;

        repeat (3) begin
            @(negedge clk_pix);
            check_outputs_idle("during reset");
        end
        @(posedge clk_pix);
        rst_sys <= 1'b0;  // 4 cycles of reset
        repeat (4) begin
            @(negedge clk_pix);
            check_outputs_idle("while the pipeline fills");
        end
        @(negedge clk_pix);  // (0,0) arrives 4 cycles after the counter
        assert (de && !hsync && !vsync)
            else stop_with_failure($sformatf("Mismatch at %0t ns: first pixel not active",
                                             $time));

        for (int i = 0; i < 16; i++) begin
            @(posedge clk_pix);
            rng = xorshift32(rng);
            pal_we   <= 1'b1;
            pal_addr <= 4'(i);
            pal_data <= colour_t'(rng[14:0]);
            pal_model[4'(i)] = rng[14:0];
        end
        @(posedge clk_pix);
        pal_we <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            @(posedge clk_pix);
            rng = xorshift32(rng);
            canv_we        <= 1'b1;
            canv_addr_w    <= 5'(i);
            canv_data.raw  <= rng[15:0];
            canv_model[5'(i)] = rng[15:0];
        end
        @(posedge clk_pix);
        canv_we <= 1'b0;

        // lock the model onto the next frame start and check two frames
        wait_for_vsync(2 * FRAME_CYCLES);
        sync_armed = 1'b1;
        wait_for_model_start(FRAME_CYCLES);
        wait_for_frames(2, 3 * FRAME_CYCLES);

        // rewrite the entry used by canvas pixel 0 while in vertical blanking
        wait_for_vsync(2 * FRAME_CYCLES);
        @(posedge clk_pix);
        upd_idx = canv_model[0][3:0];
        rng = xorshift32(rng);
        new_c = rng[14:0];
        if (new_c == pal_model[upd_idx]) new_c = ~new_c;  // force a visible change
        pal_we   <= 1'b1;
        pal_addr <= upd_idx;
        pal_data <= colour_t'(new_c);
        pal_model[upd_idx] = new_c;
        @(posedge clk_pix);
        pal_we   <= 1'b0;
        wait_for_frames(4, 3 * FRAME_CYCLES);

        if (display_top_inst.display_props_inst.err_cnt == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_with_failure("A bound property on the DUT outputs failed");
        end
    end

endmodule

//--- project.f
+incdir+rtl
rtl/display_pkg.sv
rtl/sync_bus_if.sv
rtl/display_ctrl.sv
rtl/canvas_ram.sv
rtl/palette_lut.sv
rtl/colour_expand.sv
rtl/display_top.sv
testbench/display_props.sv
testbench/display_tb.sv

//--- Makefile
# Verilator build and run of the display pixel path testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = display_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
